/* source/ip_demux_pkg.sv */
package ip_demux_pkg;

    // number of output ports and the index width that addresses them
    localparam int num_ports = 4;
    localparam int port_w    = 2;

    // payload byte width
    localparam int data_w    = 8;

    typedef logic [port_w-1:0]    port_sel_t;
    typedef logic [num_ports-1:0] port_mask_t;
    typedef logic [data_w-1:0]    data_t;

    // kept ipv4 header fields
    typedef logic [15:0] ip_len_t;
    typedef logic [7:0]  ip_ttl_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [31:0] ip_addr_t;

    // idle waits for a header, active forwards payload until tlast
    typedef enum logic [0:0] {
        frame_idle,
        frame_active
    } frame_state_t;

endpackage

/* source/ip_hdr_router.sv */
`timescale 1ns/1ps

module ip_hdr_router (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  ip_demux_pkg::port_sel_t  select,

    // header input
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  ip_demux_pkg::ip_len_t    in_ip_length,
    input  ip_demux_pkg::ip_ttl_t    in_ip_ttl,
    input  ip_demux_pkg::ip_proto_t  in_ip_protocol,
    input  ip_demux_pkg::ip_addr_t   in_ip_source,
    input  ip_demux_pkg::ip_addr_t   in_ip_dest,

    // payload input flow control
    input  logic                     in_payload_tvalid,
    input  logic                     in_payload_tlast,
    output logic                     in_payload_tready,

    // header outputs, fields shared by all ports
    output ip_demux_pkg::port_mask_t out_hdr_valid,
    input  ip_demux_pkg::port_mask_t out_hdr_ready,
    output ip_demux_pkg::ip_len_t    out_ip_length,
    output ip_demux_pkg::ip_ttl_t    out_ip_ttl,
    output ip_demux_pkg::ip_proto_t  out_ip_protocol,
    output ip_demux_pkg::ip_addr_t   out_ip_source,
    output ip_demux_pkg::ip_addr_t   out_ip_dest,

    // payload stage side
    output ip_demux_pkg::port_sel_t  cur_sel,
    output logic                     in_beat,
    input  logic                     ready_early,
    input  logic                     port_busy
);

    ip_demux_pkg::frame_state_t state;
    ip_demux_pkg::frame_state_t state_next;

    ip_demux_pkg::port_sel_t    sel_reg;
    ip_demux_pkg::port_sel_t    sel_next;

    logic                       hdr_ready_reg;
    logic                       hdr_ready_next;
    logic                       tready_reg;
    logic                       tready_next;

    ip_demux_pkg::port_mask_t   hdr_valid_reg;
    ip_demux_pkg::port_mask_t   hdr_valid_next;

    ip_demux_pkg::ip_len_t      length_reg;
    ip_demux_pkg::ip_ttl_t      ttl_reg;
    ip_demux_pkg::ip_proto_t    protocol_reg;
    ip_demux_pkg::ip_addr_t     source_reg;
    ip_demux_pkg::ip_addr_t     dest_reg;

    logic                       start;

    assign in_beat = in_payload_tvalid & tready_reg;

    // header fields are shared, so the port of the previous frame
    // must have taken its header and drained its last byte first
    assign start = (state == ip_demux_pkg::frame_idle) & enable & in_hdr_valid
                 & ~hdr_valid_reg[sel_reg] & ~port_busy;

    always_comb begin
        state_next     = state;
        sel_next       = sel_reg;
        hdr_ready_next = 1'b0;
        hdr_valid_next = hdr_valid_reg & ~out_hdr_ready;

        case (state)
            ip_demux_pkg::frame_idle: begin
                if (start) begin
                    state_next             = ip_demux_pkg::frame_active;
                    sel_next               = select;
                    hdr_ready_next         = 1'b1;
                    hdr_valid_next[select] = 1'b1;
                end
            end
            ip_demux_pkg::frame_active: begin
                // frame ends on the accepted byte marked last
                if (in_beat && in_payload_tlast) begin
                    state_next = ip_demux_pkg::frame_idle;
                end
            end
            default: begin
                state_next = ip_demux_pkg::frame_idle;
            end
        endcase

        tready_next = ready_early & (state_next == ip_demux_pkg::frame_active);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ip_demux_pkg::frame_idle;
            sel_reg       <= '0;
            hdr_ready_reg <= 1'b0;
            tready_reg    <= 1'b0;
            hdr_valid_reg <= '0;
        end else begin
            state         <= state_next;
            sel_reg       <= sel_next;
            hdr_ready_reg <= hdr_ready_next;
            tready_reg    <= tready_next;
            hdr_valid_reg <= hdr_valid_next;
        end
    end

    // header capture
    always_ff @(posedge clk) begin
        if (start) begin
            length_reg   <= in_ip_length;
            ttl_reg      <= in_ip_ttl;
            protocol_reg <= in_ip_protocol;
            source_reg   <= in_ip_source;
            dest_reg     <= in_ip_dest;
        end
    end

    assign in_hdr_ready      = hdr_ready_reg;
    assign in_payload_tready = tready_reg;
    assign out_hdr_valid     = hdr_valid_reg;
    assign cur_sel           = sel_reg;

    assign out_ip_length     = length_reg;
    assign out_ip_ttl        = ttl_reg;
    assign out_ip_protocol   = protocol_reg;
    assign out_ip_source     = source_reg;
    assign out_ip_dest       = dest_reg;

endmodule

/* source/payload_skid_demux.sv */
`timescale 1ns/1ps

module payload_skid_demux (
    input  logic                     clk,
    input  logic                     rst,

    // frame control from the router
    input  ip_demux_pkg::port_sel_t  cur_sel,
    input  logic                     in_beat,

    // accepted payload byte
    input  ip_demux_pkg::data_t      in_payload_tdata,
    input  logic                     in_payload_tlast,
    input  logic                     in_payload_tuser,

    // payload outputs, data and flags shared by all ports
    output ip_demux_pkg::port_mask_t out_payload_tvalid,
    input  ip_demux_pkg::port_mask_t out_payload_tready,
    output ip_demux_pkg::data_t      out_payload_tdata,
    output logic                     out_payload_tlast,
    output logic                     out_payload_tuser,

    output logic                     ready_early,
    output logic                     port_busy
);

    ip_demux_pkg::port_mask_t out_valid_reg;
    ip_demux_pkg::data_t      out_data_reg;
    logic                     out_last_reg;
    logic                     out_user_reg;

    logic                     skid_valid_reg;
    ip_demux_pkg::data_t      skid_data_reg;
    logic                     skid_last_reg;
    logic                     skid_user_reg;

    logic                     cur_tready;
    logic                     cur_tvalid;
    logic                     load_out;
    logic                     load_skid;
    logic                     drain_skid;

    assign cur_tready = out_payload_tready[cur_sel];
    assign cur_tvalid = out_valid_reg[cur_sel];

    // input byte goes straight out when the output slot is free or moving
    assign load_out   = in_beat & (cur_tready | ~cur_tvalid);
    // stalled output, park the byte
    assign load_skid  = in_beat & cur_tvalid & ~cur_tready;
    // no new byte, refill from the skid entry (clears valid if it is empty)
    assign drain_skid = ~in_beat & cur_tready;

    // room next cycle if the output moves, or the skid entry stays free
    assign ready_early = cur_tready
                       | (~skid_valid_reg & ~cur_tvalid)
                       | (~skid_valid_reg & ~in_beat);

    assign port_busy = cur_tvalid | skid_valid_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= '0;
            skid_valid_reg <= 1'b0;
        end else begin
            if (load_out) begin
                out_valid_reg[cur_sel] <= 1'b1;
            end else if (drain_skid) begin
                out_valid_reg[cur_sel] <= skid_valid_reg;
            end

            if (load_skid) begin
                skid_valid_reg <= 1'b1;
            end else if (drain_skid) begin
                skid_valid_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data_reg <= in_payload_tdata;
            out_last_reg <= in_payload_tlast;
            out_user_reg <= in_payload_tuser;
        end else if (drain_skid) begin
            out_data_reg <= skid_data_reg;
            out_last_reg <= skid_last_reg;
            out_user_reg <= skid_user_reg;
        end

        if (load_skid) begin
            skid_data_reg <= in_payload_tdata;
            skid_last_reg <= in_payload_tlast;
            skid_user_reg <= in_payload_tuser;
        end
    end

    assign out_payload_tvalid = out_valid_reg;
    assign out_payload_tdata  = out_data_reg;
    assign out_payload_tlast  = out_last_reg;
    assign out_payload_tuser  = out_user_reg;

endmodule

/* source/ip_demux_top.sv */
`timescale 1ns/1ps

module ip_demux_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  ip_demux_pkg::port_sel_t  select,

    // frame input
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  ip_demux_pkg::ip_len_t    in_ip_length,
    input  ip_demux_pkg::ip_ttl_t    in_ip_ttl,
    input  ip_demux_pkg::ip_proto_t  in_ip_protocol,
    input  ip_demux_pkg::ip_addr_t   in_ip_source,
    input  ip_demux_pkg::ip_addr_t   in_ip_dest,
    input  ip_demux_pkg::data_t      in_payload_tdata,
    input  logic                     in_payload_tvalid,
    output logic                     in_payload_tready,
    input  logic                     in_payload_tlast,
    input  logic                     in_payload_tuser,

    // frame outputs
    output ip_demux_pkg::port_mask_t out_hdr_valid,
    input  ip_demux_pkg::port_mask_t out_hdr_ready,
    output ip_demux_pkg::ip_len_t    out_ip_length,
    output ip_demux_pkg::ip_ttl_t    out_ip_ttl,
    output ip_demux_pkg::ip_proto_t  out_ip_protocol,
    output ip_demux_pkg::ip_addr_t   out_ip_source,
    output ip_demux_pkg::ip_addr_t   out_ip_dest,
    output ip_demux_pkg::data_t      out_payload_tdata,
    output ip_demux_pkg::port_mask_t out_payload_tvalid,
    input  ip_demux_pkg::port_mask_t out_payload_tready,
    output logic                     out_payload_tlast,
    output logic                     out_payload_tuser
);

    ip_demux_pkg::port_sel_t cur_sel;
    logic                    in_beat;
    logic                    ready_early;
    logic                    port_busy;

    ip_hdr_router u_router (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .select            (select),
        .in_hdr_valid      (in_hdr_valid),
        .in_hdr_ready      (in_hdr_ready),
        .in_ip_length      (in_ip_length),
        .in_ip_ttl         (in_ip_ttl),
        .in_ip_protocol    (in_ip_protocol),
        .in_ip_source      (in_ip_source),
        .in_ip_dest        (in_ip_dest),
        .in_payload_tvalid (in_payload_tvalid),
        .in_payload_tlast  (in_payload_tlast),
        .in_payload_tready (in_payload_tready),
        .out_hdr_valid     (out_hdr_valid),
        .out_hdr_ready     (out_hdr_ready),
        .out_ip_length     (out_ip_length),
        .out_ip_ttl        (out_ip_ttl),
        .out_ip_protocol   (out_ip_protocol),
        .out_ip_source     (out_ip_source),
        .out_ip_dest       (out_ip_dest),
        .cur_sel           (cur_sel),
        .in_beat           (in_beat),
        .ready_early       (ready_early),
        .port_busy         (port_busy)
    );

    // payload register stage, steered by the sampled select
    payload_skid_demux u_payload (
        .clk                (clk),
        .rst                (rst),
        .cur_sel            (cur_sel),
        .in_beat            (in_beat),
        .in_payload_tdata   (in_payload_tdata),
        .in_payload_tlast   (in_payload_tlast),
        .in_payload_tuser   (in_payload_tuser),
        .out_payload_tvalid (out_payload_tvalid),
        .out_payload_tready (out_payload_tready),
        .out_payload_tdata  (out_payload_tdata),
        .out_payload_tlast  (out_payload_tlast),
        .out_payload_tuser  (out_payload_tuser),
        .ready_early        (ready_early),
        .port_busy          (port_busy)
    );

endmodule

/* verification/ip_demux_tb.sv */
`timescale 1ns/1ps

module ip_demux_tb;

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic                     enable = 1'b0;
    ip_demux_pkg::port_sel_t  select = '0;
    logic                     in_hdr_valid = 1'b0;
    logic                     in_hdr_ready;
    ip_demux_pkg::ip_len_t    in_ip_length = '0;
    ip_demux_pkg::ip_ttl_t    in_ip_ttl = '0;
    ip_demux_pkg::ip_proto_t  in_ip_protocol = '0;
    ip_demux_pkg::ip_addr_t   in_ip_source = '0;
    ip_demux_pkg::ip_addr_t   in_ip_dest = '0;
    ip_demux_pkg::data_t      in_payload_tdata = '0;
    logic                     in_payload_tvalid = 1'b0;
    logic                     in_payload_tready;
    logic                     in_payload_tlast = 1'b0;
    logic                     in_payload_tuser = 1'b0;
    ip_demux_pkg::port_mask_t out_hdr_valid;
    ip_demux_pkg::port_mask_t out_hdr_ready = '1;
    ip_demux_pkg::ip_len_t    out_ip_length;
    ip_demux_pkg::ip_ttl_t    out_ip_ttl;
    ip_demux_pkg::ip_proto_t  out_ip_protocol;
    ip_demux_pkg::ip_addr_t   out_ip_source;
    ip_demux_pkg::ip_addr_t   out_ip_dest;
    ip_demux_pkg::data_t      out_payload_tdata;
    ip_demux_pkg::port_mask_t out_payload_tvalid;
    ip_demux_pkg::port_mask_t out_payload_tready = '1;
    logic                     out_payload_tlast;
    logic                     out_payload_tuser;

    integer seed = 35;
    integer value_errors = 0;
    integer other_errors = 0;
    logic   stall_now = 1'b0;

    // trace columns, one entry per frame
    int                      tr_delay[$];
    ip_demux_pkg::port_sel_t tr_sel[$];
    ip_demux_pkg::ip_len_t   tr_len[$];
    ip_demux_pkg::ip_ttl_t   tr_ttl[$];
    ip_demux_pkg::ip_proto_t tr_proto[$];
    ip_demux_pkg::ip_addr_t  tr_src[$];
    ip_demux_pkg::ip_addr_t  tr_dst[$];
    int                      tr_count[$];
    ip_demux_pkg::data_t     tr_first[$];
    logic                    tr_user[$];
    logic                    tr_stall[$];

    // output logs, {port, user, last, data} and {port, header fields}
    logic [11:0]  byte_log[$];
    logic [97:0]  hdr_log[$];

    ip_demux_top DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        out_payload_tready <= stall_now ? ip_demux_pkg::port_mask_t'($random(seed)) : '1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < ip_demux_pkg::num_ports; p++) begin
                if (out_payload_tvalid[p] && out_payload_tready[p])
                    byte_log.push_back({p[1:0], out_payload_tuser, out_payload_tlast,
                                        out_payload_tdata});
                if (out_hdr_valid[p] && out_hdr_ready[p])
                    hdr_log.push_back({p[1:0], out_ip_length, out_ip_ttl, out_ip_protocol,
                                       out_ip_source, out_ip_dest});
            end
        end
    end

    task automatic check_port(input string name, input ip_demux_pkg::port_sel_t exp,
                              input ip_demux_pkg::port_sel_t act);
        if (exp !== act) begin
            $display("** Error %s: expected port %0d, actual port %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_hdr(input string name,
                             input ip_demux_pkg::ip_len_t   e_len,
                             input ip_demux_pkg::ip_ttl_t   e_ttl,
                             input ip_demux_pkg::ip_proto_t e_pr,
                             input ip_demux_pkg::ip_addr_t  e_src,
                             input ip_demux_pkg::ip_addr_t  e_dst,
                             input ip_demux_pkg::ip_len_t   a_len,
                             input ip_demux_pkg::ip_ttl_t   a_ttl,
                             input ip_demux_pkg::ip_proto_t a_pr,
                             input ip_demux_pkg::ip_addr_t  a_src,
                             input ip_demux_pkg::ip_addr_t  a_dst);
        if ({e_len, e_ttl, e_pr, e_src, e_dst} !== {a_len, a_ttl, a_pr, a_src, a_dst}) begin
            $display("** Error %s: expected %h %h %h %h %h, actual %h %h %h %h %h", name,
                     e_len, e_ttl, e_pr, e_src, e_dst, a_len, a_ttl, a_pr, a_src, a_dst);
            value_errors++;
        end
    endtask

    task automatic check_byte(input string name, input ip_demux_pkg::data_t e_data,
                              input logic e_last, input logic e_user,
                              input ip_demux_pkg::data_t a_data,
                              input logic a_last, input logic a_user);
        if ({e_data, e_last, e_user} !== {a_data, a_last, a_user}) begin
            $display("** Error %s: expected %h last %b user %b, actual %h last %b user %b",
                     name, e_data, e_last, e_user, a_data, a_last, a_user);
            value_errors++;
        end
    endtask

    task automatic read_trace();
        integer fd;
        integer n;
        string  line;
        int     v[11];
        fd = $fopen("verification/ip_demux_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                        v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
            if (n != 11) begin
                $display("malformed trace line: %s", line);
                other_errors++;
                continue;
            end
            tr_delay.push_back(v[0]);
            tr_sel.push_back(ip_demux_pkg::port_sel_t'(v[1]));
            tr_len.push_back(ip_demux_pkg::ip_len_t'(v[2]));
            tr_ttl.push_back(ip_demux_pkg::ip_ttl_t'(v[3]));
            tr_proto.push_back(ip_demux_pkg::ip_proto_t'(v[4]));
            tr_src.push_back(v[5]);
            tr_dst.push_back(v[6]);
            tr_count.push_back(v[7]);
            tr_first.push_back(ip_demux_pkg::data_t'(v[8]));
            tr_user.push_back(v[9][0]);
            tr_stall.push_back(v[10][0]);
        end
        $fclose(fd);
    endtask

    task automatic run_frame(input int f);
        string               name;
        ip_demux_pkg::data_t exp_data;
        logic [11:0]         b;
        logic [97:0]         h;
        name = $sformatf("frame %0d", f);
        stall_now <= tr_stall[f];
        select <= tr_sel[f];
        in_hdr_valid <= 1'b1;
        in_ip_length <= tr_len[f];
        in_ip_ttl <= tr_ttl[f];
        in_ip_protocol <= tr_proto[f];
        in_ip_source <= tr_src[f];
        in_ip_dest <= tr_dst[f];
        if (tr_delay[f] > 0) begin
            enable <= 1'b0;
            repeat (tr_delay[f]) begin
                @(posedge clk);
                if (out_hdr_valid !== '0 || in_hdr_ready !== 1'b0) begin
                    $display("%s: header activity while enable is low", name);
                    other_errors++;
                end
            end
            enable <= 1'b1;
        end
        do @(posedge clk); while (in_hdr_ready !== 1'b1);
        in_hdr_valid <= 1'b0;
        for (int i = 0; i < tr_count[f]; i++) begin
            in_payload_tvalid <= 1'b1;
            in_payload_tdata <= tr_first[f] + ip_demux_pkg::data_t'(i);
            in_payload_tlast <= (i == tr_count[f] - 1);
            in_payload_tuser <= tr_user[f] && (i == tr_count[f] - 1);
            // select moves mid-frame, routing must not follow it
            if (i == 1)
                select <= tr_sel[f] + 2'd1;
            do @(posedge clk); while (in_payload_tready !== 1'b1);
        end
        in_payload_tvalid <= 1'b0;
        in_payload_tlast <= 1'b0;
        in_payload_tuser <= 1'b0;
        do @(posedge clk); while (out_payload_tvalid !== '0);

        if (hdr_log.size() != 1) begin
            $display("%s: %0d header transfers seen instead of one", name, hdr_log.size());
            other_errors++;
        end else begin
            h = hdr_log.pop_front();
            check_port({name, " hdr port"}, tr_sel[f], h[97:96]);
            check_hdr({name, " hdr"}, tr_len[f], tr_ttl[f], tr_proto[f], tr_src[f], tr_dst[f],
                      h[95:80], h[79:72], h[71:64], h[63:32], h[31:0]);
        end
        if (byte_log.size() != tr_count[f]) begin
            $display("%s: %0d payload bytes seen, %0d sent", name, byte_log.size(),
                     tr_count[f]);
            other_errors++;
        end
        for (int i = 0; i < tr_count[f] && byte_log.size() > 0; i++) begin
            b = byte_log.pop_front();
            exp_data = tr_first[f] + ip_demux_pkg::data_t'(i);
            check_port($sformatf("%s byte %0d port", name, i), tr_sel[f], b[11:10]);
            check_byte($sformatf("%s byte %0d", name, i), exp_data, i == tr_count[f] - 1,
                       tr_user[f] && (i == tr_count[f] - 1), b[7:0], b[8], b[9]);
        end
        hdr_log.delete();
        byte_log.delete();
    endtask

    initial begin
        longint limit;
        read_trace();
        limit = 16 * 10;
        foreach (tr_count[i])
            limit += (tr_count[i] + 20) * 4 * 10;
        fork
            begin
                #(limit * 1ns);
                $display("watchdog expired before the trace finished");
                $display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
                $display("Some tests failed");
                $finish;
            end
        join_none
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (in_hdr_ready !== 1'b0 || in_payload_tready !== 1'b0 || out_hdr_valid !== '0
            || out_payload_tvalid !== '0) begin
            $display("outputs not idle after reset");
            other_errors++;
        end
        enable <= 1'b1;
        foreach (tr_count[f])
            run_frame(f);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* compile.f */
source/ip_demux_pkg.sv
source/ip_hdr_router.sv
source/payload_skid_demux.sv
source/ip_demux_top.sv
verification/ip_demux_tb.sv

/* verification/ip_demux_trace.txt */
# hex columns: enable_delay select length ttl protocol source dest
#   byte_count first_byte tuser_last stall_mode
0 0 0040 40 06 0a000001 0a000002 04 10 0 0
0 1 0054 3f 11 c0a80001 c0a80002 08 20 1 0
3 2 0100 80 01 ac100001 ac100005 05 30 0 0
0 3 0028 01 06 0a0a0a0a 0b0b0b0b 01 fe 1 0
2 1 05dc ff 11 01020304 05060708 10 40 0 1
0 1 0034 20 06 c0a80101 c0a80102 0c f8 1 1
0 0 0040 40 32 0a000010 0a000020 03 00 0 0
5 3 0200 10 06 08080808 08080404 09 a0 1 1
0 2 0080 7f 11 e0000001 e0000002 02 77 0 0
1 0 0046 05 01 7f000001 7f000001 14 c0 1 1
0 3 0030 33 06 0a141e28 32a4b5c6 06 55 0 1
0 2 0090 99 2f deadbeef cafef00d 07 e0 1 0
